/* rtl/fifo_pkg.sv */
`default_nettype none

package fifo_pkg;

  // Status word, shared by the write view and the read view.
  localparam int STATUS_W = 16;

  localparam int LEVEL_LSB       = 0;
  localparam int LEVEL_W         = 8;
  localparam int STAT_FLAG_BIT   = 8; // Full (write side) or empty (read side).
  localparam int STAT_ALMOST_BIT = 9; // Almost-full or almost-empty.

  typedef logic [STATUS_W-1:0] status_t;

  // Labels the two views of the FIFO.
  typedef enum logic {
    SIDE_WR = 1'b0,
    SIDE_RD = 1'b1
  } fifo_side_e;

  function automatic status_t pack_status(input logic [LEVEL_W-1:0] level,
                                          input logic               flag,
                                          input logic               almost);
    status_t word;
    word                         = '0;
    word[LEVEL_LSB +: LEVEL_W]   = level;
    word[STAT_FLAG_BIT]          = flag;
    word[STAT_ALMOST_BIT]        = almost;
    return word;
  endfunction

endpackage

`default_nettype wire

/* rtl/wb_pkg.sv */
`default_nettype none

package wb_pkg;

  // Register map, one address bit.
  typedef enum logic {
    REG_DATA   = 1'b0,
    REG_STATUS = 1'b1
  } wb_reg_e;

  // Push port FSM.
  typedef enum logic {
    PS_IDLE,
    PS_ACK
  } push_state_e;

  // Pop port FSM. PP_READ waits for the RAM output register.
  typedef enum logic [1:0] {
    PP_IDLE,
    PP_READ,
    PP_ACK
  } pop_state_e;

endpackage

`default_nettype wire

/* rtl/dualport_ram.sv */
`default_nettype none

module dualport_ram #(
  parameter int DATA_WIDTH = 16,
  parameter int ADDR_WIDTH = 4
) (
  input  logic                  wr_clk,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [DATA_WIDTH-1:0] rd_data
);

  localparam int DEPTH = 1 << ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // Write port.
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read port, only updated on a pop.
  always_ff @(posedge rd_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

/* rtl/async_fifo.sv */
`default_nettype none

module async_fifo #(
  parameter int DATA_WIDTH  = 16,
  parameter int ADDR_WIDTH  = 4,
  parameter int FIFO_AFULL  = 14,
  parameter int FIFO_AEMPTY = 2
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  push,
  input  logic [DATA_WIDTH-1:0] wdata,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  pop,
  output logic [DATA_WIDTH-1:0] rdata,
  output logic                  full,
  output logic                  afull,
  output logic [ADDR_WIDTH:0]   wr_level,
  output logic                  empty,
  output logic                  aempty,
  output logic [ADDR_WIDTH:0]   rd_level
);

  localparam logic [ADDR_WIDTH:0] DEPTH = (ADDR_WIDTH+1)'(1 << ADDR_WIDTH);

  function automatic logic [ADDR_WIDTH:0] bin2gray(input logic [ADDR_WIDTH:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic logic [ADDR_WIDTH:0] gray2bin(input logic [ADDR_WIDTH:0] gray);
    logic [ADDR_WIDTH:0] bin;
    bin[ADDR_WIDTH] = gray[ADDR_WIDTH];
    for (int i = ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

  logic [ADDR_WIDTH:0] wr_bin, wr_bin_nxt, wr_gray;
  logic [ADDR_WIDTH:0] rd_bin, rd_bin_nxt, rd_gray;
  logic [ADDR_WIDTH:0] rd_gray_s1, rd_gray_s2, rd_bin_sync; // Read pointer in wr_clk.
  logic [ADDR_WIDTH:0] wr_gray_s1, wr_gray_s2, wr_bin_sync; // Write pointer in rd_clk.
  logic [ADDR_WIDTH:0] wr_level_nxt, rd_level_nxt;

  dualport_ram #(
    .DATA_WIDTH(DATA_WIDTH),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) i_ram (
    .wr_clk (wr_clk),
    .wr_en  (push),
    .wr_addr(wr_bin[ADDR_WIDTH-1:0]),
    .wr_data(wdata),
    .rd_clk (rd_clk),
    .rd_en  (pop),
    .rd_addr(rd_bin[ADDR_WIDTH-1:0]),
    .rd_data(rdata)
  );

  // Write side.
  assign wr_bin_nxt   = wr_bin + (ADDR_WIDTH+1)'(push);
  assign rd_bin_sync  = gray2bin(rd_gray_s2);
  assign wr_level_nxt = wr_bin_nxt - rd_bin_sync;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin     <= '0;
      wr_gray    <= '0;
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
      wr_level   <= '0;
      full       <= 1'b0;
      afull      <= 1'b0;
    end else begin
      wr_bin     <= wr_bin_nxt;
      wr_gray    <= bin2gray(wr_bin_nxt);
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
      wr_level   <= wr_level_nxt;
      full       <= (wr_level_nxt == DEPTH);
      afull      <= (wr_level_nxt >= FIFO_AFULL);
    end
  end

  // Read side.
  assign rd_bin_nxt   = rd_bin + (ADDR_WIDTH+1)'(pop);
  assign wr_bin_sync  = gray2bin(wr_gray_s2);
  assign rd_level_nxt = wr_bin_sync - rd_bin_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin     <= '0;
      rd_gray    <= '0;
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
      rd_level   <= '0;
      empty      <= 1'b1;
      aempty     <= 1'b1; // Level 0 is below any threshold.
    end else begin
      rd_bin     <= rd_bin_nxt;
      rd_gray    <= bin2gray(rd_bin_nxt);
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1;
      rd_level   <= rd_level_nxt;
      empty      <= (rd_level_nxt == '0);
      aempty     <= (rd_level_nxt <= FIFO_AEMPTY);
    end
  end

  a_no_push_full: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    !(push && full));

  a_no_pop_empty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    !(pop && empty));

  // Only one bit may move per edge, or the synchronizer can sample garbage.
  a_wr_gray_step: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    $onehot0(wr_gray ^ $past(wr_gray)));

  a_rd_gray_step: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    $onehot0(rd_gray ^ $past(rd_gray)));

endmodule

`default_nettype wire

/* rtl/wb_push_port.sv */
`default_nettype none

module wb_push_port
  import wb_pkg::*;
  import fifo_pkg::*;
#(
  parameter int DATA_WIDTH = 16
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_cyc,
  input  logic                  wr_stb,
  input  logic                  wr_we,
  input  logic                  wr_adr,
  input  logic [DATA_WIDTH-1:0] wr_dat_w,
  input  logic                  full,
  input  logic                  afull,
  input  logic [LEVEL_W-1:0]    wr_level,
  output logic [DATA_WIDTH-1:0] wr_dat_r,
  output logic                  wr_ack,
  output logic                  push,
  output logic [DATA_WIDTH-1:0] wdata
);

  push_state_e state;
  wb_reg_e     reg_sel;
  logic        req;
  logic        data_wr;
  logic        accept;
  status_t     status;

  assign reg_sel = wb_reg_e'(wr_adr);
  assign req     = wr_cyc && wr_stb && (state == PS_IDLE);
  assign data_wr = wr_we && (reg_sel == REG_DATA);
  assign accept  = req && !(data_wr && full); // Hold off while full.
  assign push    = req && data_wr && !full;
  assign wdata   = wr_dat_w;
  assign status  = pack_status(wr_level, full, afull);
  assign wr_ack  = (state == PS_ACK);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      state <= PS_IDLE;
    end else if (state == PS_ACK) begin
      state <= PS_IDLE;
    end else if (accept) begin
      state <= PS_ACK;
    end
  end

  // Read data.
  always_ff @(posedge wr_clk) begin
    if (accept) begin
      wr_dat_r <= (reg_sel == REG_STATUS) ? DATA_WIDTH'(status) : '0;
    end
  end

  a_ack_in_cycle: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    wr_ack |-> wr_cyc && wr_stb);

endmodule

`default_nettype wire

/* rtl/wb_pop_port.sv */
`default_nettype none

module wb_pop_port
  import wb_pkg::*;
  import fifo_pkg::*;
#(
  parameter int DATA_WIDTH = 16
) (
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_cyc,
  input  logic                  rd_stb,
  input  logic                  rd_we,
  input  logic                  rd_adr,
  input  logic [DATA_WIDTH-1:0] rdata,
  input  logic                  empty,
  input  logic                  aempty,
  input  logic [LEVEL_W-1:0]    rd_level,
  output logic [DATA_WIDTH-1:0] rd_dat_r,
  output logic                  rd_ack,
  output logic                  pop
);

  pop_state_e state;
  wb_reg_e    reg_sel;
  logic       req;
  logic       data_rd;
  logic       direct;
  status_t    status;

  assign reg_sel = wb_reg_e'(rd_adr);
  assign req     = rd_cyc && rd_stb && (state == PP_IDLE);
  assign data_rd = !rd_we && (reg_sel == REG_DATA);
  assign pop     = req && data_rd && !empty;
  assign direct  = req && !data_rd; // Status reads and ignored writes.
  assign status  = pack_status(rd_level, empty, aempty);
  assign rd_ack  = (state == PP_ACK);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      state <= PP_IDLE;
    end else begin
      case (state)
        PP_IDLE: begin
          if (pop) begin
            state <= PP_READ;
          end else if (direct) begin
            state <= PP_ACK;
          end
        end
        PP_READ: state <= PP_ACK; // RAM output is valid now.
        PP_ACK:  state <= PP_IDLE;
        default: state <= PP_IDLE;
      endcase
    end
  end

  always_ff @(posedge rd_clk) begin
    if (state == PP_READ) begin
      rd_dat_r <= rdata;
    end else if (direct) begin
      rd_dat_r <= (reg_sel == REG_STATUS) ? DATA_WIDTH'(status) : '0;
    end
  end

  // A popped word is lost unless the master holds the strobe until the ack.
  a_pop_held: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    pop |=> (rd_cyc && rd_stb) ##1 (rd_cyc && rd_stb));

endmodule

`default_nettype wire

/* rtl/wb_fifo_bridge.sv */
`default_nettype none

module wb_fifo_bridge
  import fifo_pkg::*;
#(
  parameter int DATA_WIDTH  = 16,
  parameter int ADDR_WIDTH  = 4,
  parameter int FIFO_AFULL  = 14,
  parameter int FIFO_AEMPTY = 2
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_cyc,
  input  logic                  wr_stb,
  input  logic                  wr_we,
  input  logic                  wr_adr,
  input  logic [DATA_WIDTH-1:0] wr_dat_w,
  output logic [DATA_WIDTH-1:0] wr_dat_r,
  output logic                  wr_ack,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_cyc,
  input  logic                  rd_stb,
  input  logic                  rd_we,
  input  logic                  rd_adr,
  output logic [DATA_WIDTH-1:0] rd_dat_r,
  output logic                  rd_ack
);

  logic                  push;
  logic                  pop;
  logic [DATA_WIDTH-1:0] wdata;
  logic [DATA_WIDTH-1:0] rdata;
  logic                  full, afull;
  logic                  empty, aempty;
  logic [ADDR_WIDTH:0]   wr_level, rd_level;

  wb_push_port #(
    .DATA_WIDTH(DATA_WIDTH)
  ) i_push (
    .wr_clk  (wr_clk),
    .wr_rst_n(wr_rst_n),
    .wr_cyc  (wr_cyc),
    .wr_stb  (wr_stb),
    .wr_we   (wr_we),
    .wr_adr  (wr_adr),
    .wr_dat_w(wr_dat_w),
    .full    (full),
    .afull   (afull),
    .wr_level(LEVEL_W'(wr_level)),
    .wr_dat_r(wr_dat_r),
    .wr_ack  (wr_ack),
    .push    (push),
    .wdata   (wdata)
  );

  async_fifo #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH),
    .FIFO_AFULL (FIFO_AFULL),
    .FIFO_AEMPTY(FIFO_AEMPTY)
  ) i_fifo (
    .wr_clk  (wr_clk),
    .wr_rst_n(wr_rst_n),
    .push    (push),
    .wdata   (wdata),
    .rd_clk  (rd_clk),
    .rd_rst_n(rd_rst_n),
    .pop     (pop),
    .rdata   (rdata),
    .full    (full),
    .afull   (afull),
    .wr_level(wr_level),
    .empty   (empty),
    .aempty  (aempty),
    .rd_level(rd_level)
  );

  wb_pop_port #(
    .DATA_WIDTH(DATA_WIDTH)
  ) i_pop (
    .rd_clk  (rd_clk),
    .rd_rst_n(rd_rst_n),
    .rd_cyc  (rd_cyc),
    .rd_stb  (rd_stb),
    .rd_we   (rd_we),
    .rd_adr  (rd_adr),
    .rdata   (rdata),
    .empty   (empty),
    .aempty  (aempty),
    .rd_level(LEVEL_W'(rd_level)),
    .rd_dat_r(rd_dat_r),
    .rd_ack  (rd_ack),
    .pop     (pop)
  );

endmodule

`default_nettype wire

/* sim/tb_wb_fifo.sv */
`default_nettype none

module tb_wb_fifo
  import wb_pkg::*;
  import fifo_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DATA_WIDTH  = 16;
  localparam int ADDR_WIDTH  = 4;
  localparam int FIFO_AFULL  = 14;
  localparam int FIFO_AEMPTY = 2;
  localparam int DEPTH       = 1 << ADDR_WIDTH;
  localparam int N_RANDOM    = 400;
  // Random traffic, full-FIFO test with drain, empty wait and eight two-sided status checks.
  localparam int N_OPS       = 2 * N_RANDOM + 2 * (DEPTH + 1) + 2 + 2 * 8;
  localparam int CYCLE_LIMIT = 20 * N_OPS + 2000;

  logic                  wr_clk = 1'b0;
  logic                  rd_clk = 1'b0;
  logic                  wr_rst_n, rd_rst_n;
  logic                  wr_cyc, wr_stb, wr_we, wr_adr;
  logic [DATA_WIDTH-1:0] wr_dat_w, wr_dat_r;
  logic                  wr_ack;
  logic                  rd_cyc, rd_stb, rd_we, rd_adr;
  logic [DATA_WIDTH-1:0] rd_dat_r;
  logic                  rd_ack;

  logic [15:0]           lfsr = 16'd23660;
  logic [DATA_WIDTH-1:0] model[$]; // Words pushed and not yet popped.
  int unsigned           cycles = 0;

  always #4 wr_clk = ~wr_clk;
  always #6.5 rd_clk = ~rd_clk;

  wb_fifo_bridge #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH),
    .FIFO_AFULL (FIFO_AFULL),
    .FIFO_AEMPTY(FIFO_AEMPTY)
  ) i_dut (
    .wr_clk  (wr_clk),
    .wr_rst_n(wr_rst_n),
    .wr_cyc  (wr_cyc),
    .wr_stb  (wr_stb),
    .wr_we   (wr_we),
    .wr_adr  (wr_adr),
    .wr_dat_w(wr_dat_w),
    .wr_dat_r(wr_dat_r),
    .wr_ack  (wr_ack),
    .rd_clk  (rd_clk),
    .rd_rst_n(rd_rst_n),
    .rd_cyc  (rd_cyc),
    .rd_stb  (rd_stb),
    .rd_we   (rd_we),
    .rd_adr  (rd_adr),
    .rd_dat_r(rd_dat_r),
    .rd_ack  (rd_ack)
  );

  // Galois LFSR, one step per bit.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return val;
  endfunction

  function automatic status_t expect_status(input fifo_side_e side, input int level);
    status_t word;
    word                       = '0;
    word[LEVEL_LSB +: LEVEL_W] = LEVEL_W'(level);
    if (side == SIDE_WR) begin
      word[STAT_FLAG_BIT]   = (level == DEPTH);
      word[STAT_ALMOST_BIT] = (level >= FIFO_AFULL);
    end else begin
      word[STAT_FLAG_BIT]   = (level == 0);
      word[STAT_ALMOST_BIT] = (level <= FIFO_AEMPTY);
    end
    return word;
  endfunction

  task automatic fail_stop();
    $display("Test FAILED");
    $fatal(1, "Simulation stopped on error.");
  endtask

  task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] got,
                            input logic [DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("ERR %0t ns %s got 0x%04h expected 0x%04h", $time, name, got, exp);
      fail_stop();
    end
  endtask

  task automatic check_status(input fifo_side_e side, input status_t got, input status_t exp);
    if (got !== exp) begin
      $display("ERR %0t ns %s (%s status) got 0x%04h expected 0x%04h", $time,
               (side == SIDE_WR) ? "wr_dat_r" : "rd_dat_r", side.name(), got, exp);
      fail_stop();
    end
  endtask

  // Wishbone classic master on the push bus.
  task automatic wr_access(input logic we, input wb_reg_e adr,
                           input logic [DATA_WIDTH-1:0] dat,
                           output logic [DATA_WIDTH-1:0] rdat);
    @(posedge wr_clk);
    wr_cyc   <= 1'b1;
    wr_stb   <= 1'b1;
    wr_we    <= we;
    wr_adr   <= adr;
    wr_dat_w <= dat;
    do begin
      @(posedge wr_clk);
    end while (!wr_ack);
    rdat = wr_dat_r;
    wr_cyc <= 1'b0;
    wr_stb <= 1'b0;
    wr_we  <= 1'b0;
  endtask

  task automatic rd_access(input logic we, input wb_reg_e adr,
                           output logic [DATA_WIDTH-1:0] rdat);
    @(posedge rd_clk);
    rd_cyc <= 1'b1;
    rd_stb <= 1'b1;
    rd_we  <= we;
    rd_adr <= adr;
    do begin
      @(posedge rd_clk);
    end while (!rd_ack);
    rdat = rd_dat_r;
    rd_cyc <= 1'b0;
    rd_stb <= 1'b0;
  endtask

  task automatic push_word(input logic [DATA_WIDTH-1:0] word);
    logic [DATA_WIDTH-1:0] unused;
    model.push_back(word); // Recorded before it can reach the read side.
    wr_access(1'b1, REG_DATA, word, unused);
  endtask

  task automatic pop_check();
    logic [DATA_WIDTH-1:0] got;
    rd_access(1'b0, REG_DATA, got);
    if (model.size() == 0) begin
      $display("A pop returned data although nothing was pushed, at %0t ns", $time);
      fail_stop();
    end
    check_data("rd_dat_r", got, model.pop_front());
  endtask

  task automatic check_levels();
    logic [DATA_WIDTH-1:0] rdat;
    repeat (8) @(posedge wr_clk);
    repeat (8) @(posedge rd_clk);
    wr_access(1'b0, REG_STATUS, '0, rdat);
    check_status(SIDE_WR, status_t'(rdat), expect_status(SIDE_WR, model.size()));
    rd_access(1'b0, REG_STATUS, rdat);
    check_status(SIDE_RD, status_t'(rdat), expect_status(SIDE_RD, model.size()));
  endtask

  task automatic check_at(input int level);
    while (model.size() < level) begin
      push_word(DATA_WIDTH'(rand_bits(DATA_WIDTH)));
    end
    check_levels();
  endtask

  // 17th push must stall until a pop frees a slot.
  task automatic check_back_pressure();
    bit acked;
    acked = 1'b0;
    fork
      begin
        push_word(DATA_WIDTH'(rand_bits(DATA_WIDTH)));
        acked = 1'b1;
      end
      begin
        repeat (40) @(posedge wr_clk);
        if (acked) begin
          $display("A push to the full FIFO was acked before any pop, at %0t ns", $time);
          fail_stop();
        end
        pop_check();
      end
    join
  endtask

  task automatic check_empty_wait();
    logic [DATA_WIDTH-1:0] got;
    bit                    popped;
    popped = 1'b0;
    fork
      begin
        rd_access(1'b0, REG_DATA, got);
        popped = 1'b1;
      end
      begin
        repeat (20) @(posedge rd_clk);
        if (popped) begin
          $display("A pop from the empty FIFO was acked before any push, at %0t ns", $time);
          fail_stop();
        end
        push_word(DATA_WIDTH'(rand_bits(DATA_WIDTH)));
      end
    join
    check_data("rd_dat_r", got, model.pop_front());
  endtask

  task automatic run_pusher(input int count);
    int done_cnt;
    int burst;
    done_cnt = 0;
    while (done_cnt < count) begin
      burst = 1 + int'(rand_bits(2));
      while (burst > 0 && done_cnt < count) begin
        push_word(DATA_WIDTH'(rand_bits(DATA_WIDTH)));
        done_cnt++;
        burst--;
      end
      repeat (int'(rand_bits(4))) @(posedge wr_clk);
    end
  endtask

  task automatic run_popper(input int count);
    int done_cnt;
    int burst;
    done_cnt = 0;
    while (done_cnt < count) begin
      burst = 1 + int'(rand_bits(2));
      while (burst > 0 && done_cnt < count) begin
        pop_check();
        done_cnt++;
        burst--;
      end
      repeat (int'(rand_bits(2))) @(posedge rd_clk);
    end
  endtask

  always @(posedge wr_clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d wr_clk cycles, a bus access never completed", cycles);
      fail_stop();
    end
  end

  initial begin
    wr_rst_n <= 1'b0;
    rd_rst_n <= 1'b0;
    wr_cyc   <= 1'b0;
    wr_stb   <= 1'b0;
    wr_we    <= 1'b0;
    wr_adr   <= REG_DATA;
    wr_dat_w <= '0;
    rd_cyc   <= 1'b0;
    rd_stb   <= 1'b0;
    rd_we    <= 1'b0;
    rd_adr   <= REG_DATA;
    repeat (8) @(posedge wr_clk);
    wr_rst_n <= 1'b1;
    @(posedge rd_clk);
    rd_rst_n <= 1'b1;

    check_levels(); // Reset state.
    check_at(2);
    check_at(3);
    check_at(13);
    check_at(FIFO_AFULL);
    check_at(DEPTH);
    check_back_pressure();
    while (model.size() > 0) begin
      pop_check();
    end
    check_levels();
    check_empty_wait();

    fork
      run_pusher(N_RANDOM);
      run_popper(N_RANDOM);
    join
    check_levels();

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
rtl/fifo_pkg.sv
rtl/wb_pkg.sv
rtl/dualport_ram.sv
rtl/async_fifo.sv
rtl/wb_push_port.sv
rtl/wb_pop_port.sv
rtl/wb_fifo_bridge.sv
sim/tb_wb_fifo.sv

/* Bender.yml */
package:
  name: wb_fifo_bridge

sources:
  - rtl/fifo_pkg.sv
  - rtl/wb_pkg.sv
  - rtl/dualport_ram.sv
  - rtl/async_fifo.sv
  - rtl/wb_push_port.sv
  - rtl/wb_pop_port.sv
  - rtl/wb_fifo_bridge.sv
  - target: simulation
    files:
      - sim/tb_wb_fifo.sv
